// ==== source/cabinet_io_defines.svh ====
// ========================================
// Cabinet I/O definitions
// Download indexes, DIP bank depth, word
// widths and the released input port value
// ========================================

`ifndef CABINET_IO_DEFINES_SVH
`define CABINET_IO_DEFINES_SVH

// ========================================
// Download stream
// ========================================

// Loader index that carries the game select code
`define CIO_INDEX_GAME 8'd1
// Loader index that carries the DIP switch bytes
`define CIO_INDEX_DIP 8'd254
// Width of the loader index field
`define CIO_INDEX_W 8
// Loader byte address width
`define CIO_ADDR_W 25
// Byte width, shared by loader data, DIP bytes and ports
`define CIO_DATA_W 8

// ========================================
// DIP bank and controls
// ========================================

// Eight switch bytes, only the first three reach the ports
`define CIO_DIP_COUNT 8
// Byte select width inside the bank
`define CIO_SEL_W $clog2(`CIO_DIP_COUNT)
// One joystick word from the host
`define CIO_JOY_W 16
// Input ports are active low, so idle means every bit released
`define CIO_PORT_IDLE {`CIO_DATA_W{1'b1}}

`endif

// ==== source/cabinet_io_pkg.sv ====
// ========================================
// Cabinet I/O types
// Loader writes, bank writes, game select,
// joystick words and the input port bundle
// ========================================

`include "cabinet_io_defines.svh"

package cabinet_io_pkg;

	// One write from the loader, valid when wr is high
	typedef struct packed {
		logic                    wr;
		logic [`CIO_INDEX_W-1:0] index;
		logic [`CIO_ADDR_W-1:0]  addr;
		logic [`CIO_DATA_W-1:0]  data;
	} download_write_t;

	// Single cycle write into the DIP bank
	typedef struct packed {
		logic                   en;
		logic [`CIO_SEL_W-1:0]  sel;
		logic [`CIO_DATA_W-1:0] data;
	} dip_write_t;

	// Selected game, codes 0 to 3 in this order, anything else is none
	typedef enum logic [2:0] {
		game_bwidow,
		game_gravitar,
		game_lunarbat,
		game_spacduel,
		game_none
	} game_e;

	// Player 1 word, read as the move stick plus its fire buttons
	typedef struct packed {
		logic [`CIO_JOY_W-12:0] spare;
		logic coin;
		logic start_2;
		logic start_1;
		logic fire_down;
		logic fire_up;
		logic fire_left;
		logic fire_right;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_move_t;

	// Player 2 word, the stick drives fire directions
	typedef struct packed {
		logic [`CIO_JOY_W-12:0] spare;
		logic coin;
		logic start_2;
		logic start_1;
		logic [3:0] unused;
		logic fire_up;
		logic fire_down;
		logic fire_left;
		logic fire_right;
	} joy_fire_t;

	// Same host word, two decodings depending on the player
	typedef union packed {
		joy_move_t as_move;
		joy_fire_t as_fire;
	} joy_word_u;

	// DIP bytes that the games actually read
	typedef struct packed {
		logic [`CIO_DATA_W-1:0] sw2;
		logic [`CIO_DATA_W-1:0] sw1;
		logic [`CIO_DATA_W-1:0] sw0;
	} dip_view_t;

	// Five active low input ports toward the CPU board
	typedef struct packed {
		logic [`CIO_DATA_W-1:0] in4;
		logic [`CIO_DATA_W-1:0] in3;
		logic [`CIO_DATA_W-1:0] in2;
		logic [`CIO_DATA_W-1:0] in1;
		logic [`CIO_DATA_W-1:0] in0;
	} cabinet_ports_t;

endpackage

// ==== source/download_decoder.sv ====
// ========================================
// Download decoder
// Picks the game code and DIP byte writes
// out of the loader write stream
// ========================================

`timescale 1ns/1ps
`include "cabinet_io_defines.svh"

module download_decoder (
	input  logic                            clk_12,
	input  logic                            reset,
	input  cabinet_io_pkg::download_write_t download,
	output cabinet_io_pkg::dip_write_t      dip_write,
	output cabinet_io_pkg::game_e           game
);
	import cabinet_io_pkg::*;

	// Raw code byte from the loader
	logic [`CIO_DATA_W-1:0] game_code;
	// Registered bank write, split into control and payload
	logic                   dip_en_q;
	logic [`CIO_SEL_W-1:0]  dip_sel_q;
	logic [`CIO_DATA_W-1:0] dip_data_q;
	// Loader write aimed at the game select
	logic                   game_hit;
	// Loader write aimed at a byte inside the bank
	logic                   dip_hit;

	// Codes past the known titles fall back to none
	function automatic game_e code_to_game(input logic [`CIO_DATA_W-1:0] code);
		case (code)
			8'd0: code_to_game = game_bwidow;
			8'd1: code_to_game = game_gravitar;
			8'd2: code_to_game = game_lunarbat;
			8'd3: code_to_game = game_spacduel;
			default: code_to_game = game_none;
		endcase
	endfunction

	assign game_hit = download.wr && (download.index == `CIO_INDEX_GAME);
	// Upper address bits clear means the byte lands in the bank
	assign dip_hit = download.wr && (download.index == `CIO_INDEX_DIP)
		&& (download.addr[`CIO_ADDR_W-1:`CIO_SEL_W] == '0);

	// ========================================
	// Game select, two register stages
	// ========================================
	always_ff @(posedge clk_12) begin
		if (reset) begin
			game_code <= '0;
			game      <= game_bwidow;
		end else begin
			if (game_hit) begin
				game_code <= download.data;
			end
			game <= code_to_game(game_code);
		end
	end

	// ========================================
	// DIP writes toward the bank
	// ========================================
	always_ff @(posedge clk_12) begin
		if (reset) begin
			dip_en_q <= 1'b0;
		end else begin
			dip_en_q <= dip_hit;
		end
	end

	// Payload only matters while the strobe is up
	always_ff @(posedge clk_12) begin
		if (dip_hit) begin
			dip_sel_q  <= download.addr[`CIO_SEL_W-1:0];
			dip_data_q <= download.data;
		end
	end

	assign dip_write = '{en: dip_en_q, sel: dip_sel_q, data: dip_data_q};

	// Every bank strobe traces back to a DIP index write one cycle earlier
	a_dip_from_loader: assert property (@(posedge clk_12) disable iff (reset)
		dip_write.en |-> $past(download.wr && (download.index == `CIO_INDEX_DIP)));

endmodule

// ==== source/dip_bank.sv ====
// ========================================
// DIP switch bank
// Eight switch bytes, first three exposed
// ========================================

`timescale 1ns/1ps
`include "cabinet_io_defines.svh"

module dip_bank (
	input  logic                       clk_12,
	input  logic                       reset,
	input  cabinet_io_pkg::dip_write_t dip_write,
	output cabinet_io_pkg::dip_view_t  dips
);

	// Switch storage, bytes 3 to 7 are kept for later boards
	logic [`CIO_DATA_W-1:0] bank [`CIO_DIP_COUNT];

	// ========================================
	// Byte writes
	// ========================================
	// All switches open after reset
	always_ff @(posedge clk_12) begin
		if (reset) begin
			for (int i = 0; i < `CIO_DIP_COUNT; i++) begin
				bank[i] <= '0;
			end
		end else if (dip_write.en) begin
			bank[dip_write.sel] <= dip_write.data;
		end
	end

	// Coinage and difficulty bytes, plus the option byte
	assign dips.sw0 = bank[0];
	assign dips.sw1 = bank[1];
	assign dips.sw2 = bank[2];

	// An unknown select would smear the write across the bank
	a_sel_known: assert property (@(posedge clk_12) disable iff (reset)
		dip_write.en |-> !$isunknown(dip_write.sel));

endmodule

// ==== source/input_mapper.sv ====
// ========================================
// Input mapper
// Merges both sticks and forms the five
// active low ports for the selected game
// ========================================

`timescale 1ns/1ps
`include "cabinet_io_defines.svh"

module input_mapper (
	input  logic                           clk_12,
	input  logic                           reset,
	input  cabinet_io_pkg::game_e          game,
	input  cabinet_io_pkg::dip_view_t      dips,
	input  cabinet_io_pkg::joy_word_u      joy_0,
	input  cabinet_io_pkg::joy_word_u      joy_1,
	output cabinet_io_pkg::cabinet_ports_t ports
);
	import cabinet_io_pkg::*;

	// Merged cabinet controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_up;
		logic fire_down;
		logic fire_left;
		logic fire_right;
		logic start_1;
		logic start_2;
		logic coin;
	} controls_t;

	localparam cabinet_ports_t ports_idle = '{default: `CIO_PORT_IDLE};

	controls_t      ctl;
	cabinet_ports_t ports_next;
	// Coin and option bits are shared by the three Atari boards
	logic [`CIO_DATA_W-1:0] in0_shared;

	// ========================================
	// Stick merge
	// ========================================
	// Player 1 owns movement
	assign ctl.up    = joy_0.as_move.up;
	assign ctl.down  = joy_0.as_move.down;
	assign ctl.left  = joy_0.as_move.left;
	assign ctl.right = joy_0.as_move.right;

	// Fire comes from player 1 buttons or the player 2 stick
	assign ctl.fire_up    = joy_0.as_move.fire_up | joy_1.as_fire.fire_up;
	assign ctl.fire_down  = joy_0.as_move.fire_down | joy_1.as_fire.fire_down;
	assign ctl.fire_left  = joy_0.as_move.fire_left | joy_1.as_fire.fire_left;
	assign ctl.fire_right = joy_0.as_move.fire_right | joy_1.as_fire.fire_right;

	// Either pad can start or coin up
	assign ctl.start_1 = joy_0.as_move.start_1 | joy_1.as_fire.start_1;
	assign ctl.start_2 = joy_0.as_move.start_2 | joy_1.as_fire.start_2;
	assign ctl.coin    = joy_0.as_move.coin | joy_1.as_fire.coin;

	// Bit 6 low, sw2 option bits swapped, second coin never pressed
	assign in0_shared = {1'b1, 1'b0, ~dips.sw2[0], ~dips.sw2[1], 1'b1, 1'b1, ~ctl.coin, 1'b1};

	// ========================================
	// Per game port map
	// ========================================
	always_comb begin
		// Space Duel and no game keep the switch bytes and idle buttons
		ports_next     = ports_idle;
		ports_next.in1 = dips.sw0;
		ports_next.in2 = dips.sw1;

		case (game)
			game_bwidow: begin
				ports_next.in0 = in0_shared;
				// Move stick on the low nibble
				ports_next.in3 = {4'b1111, ~ctl.up, ~ctl.down, ~ctl.left, ~ctl.right};
				ports_next.in4 = {1'b1, ~ctl.start_2, ~ctl.start_1, 1'b1,
					~ctl.fire_up, ~ctl.fire_down, ~ctl.fire_left, ~ctl.fire_right};
			end
			game_gravitar: begin
				ports_next.in0 = in0_shared;
				// Rotate, fire, thrust and shield
				ports_next.in3 = {3'b111, ~ctl.fire_left, ~ctl.left, ~ctl.right,
					~ctl.fire_right, ~ctl.fire_down};
				ports_next.in4 = {1'b1, ~ctl.start_2, ~ctl.start_1, 5'b11111};
			end
			game_lunarbat: begin
				ports_next.in0 = in0_shared;
				// This board reads in3 active high and no switch bytes
				ports_next.in1 = `CIO_PORT_IDLE;
				ports_next.in2 = `CIO_PORT_IDLE;
				ports_next.in3 = {1'b0, ctl.start_2, ctl.start_1, ctl.fire_left,
					ctl.fire_down, ctl.fire_right, ctl.right, ctl.left};
			end
			default: begin
			end
		endcase
	end

	// ========================================
	// Port register
	// ========================================
	// Everything released for the first cycle out of reset
	always_ff @(posedge clk_12) begin
		if (reset) begin
			ports <= ports_idle;
		end else begin
			ports <= ports_next;
		end
	end

	// Lunar Battle must never see buttons or switches on in1 and in4
	a_lunarbat_idle: assert property (@(posedge clk_12) disable iff (reset)
		(game == game_lunarbat)
			|=> (ports.in1 == `CIO_PORT_IDLE) && (ports.in4 == `CIO_PORT_IDLE));

endmodule

// ==== source/cabinet_io_top.sv ====
// ========================================
// Cabinet input front end
// Loader decode, DIP bank and port mapping
// ========================================

`timescale 1ns/1ps

module cabinet_io_top (
	input  logic                           clk_12,
	input  logic                           reset,
	// Loader write stream
	input  cabinet_io_pkg::download_write_t download,
	// Host joystick words for both players
	input  cabinet_io_pkg::joy_word_u      joy_0,
	input  cabinet_io_pkg::joy_word_u      joy_1,
	// Active low inputs toward the CPU board
	output cabinet_io_pkg::cabinet_ports_t ports
);
	import cabinet_io_pkg::*;

	// ========================================
	// Internal links
	// ========================================
	// Decoder to bank, single cycle strobe
	dip_write_t dip_write;
	// Decoder to mapper, level
	game_e      game;
	// Bank to mapper, level
	dip_view_t  dips;

	// Loader side, produces game select and bank writes
	download_decoder u_download_decoder (
		.clk_12    (clk_12),
		.reset     (reset),
		.download  (download),
		.dip_write (dip_write),
		.game      (game)
	);

	// Holds the switch bytes
	dip_bank u_dip_bank (
		.clk_12    (clk_12),
		.reset     (reset),
		.dip_write (dip_write),
		.dips      (dips)
	);

	// Game specific port layout
	input_mapper u_input_mapper (
		.clk_12 (clk_12),
		.reset  (reset),
		.game   (game),
		.dips   (dips),
		.joy_0  (joy_0),
		.joy_1  (joy_1),
		.ports  (ports)
	);

endmodule

// ==== bench/tb_cabinet_io.sv ====
// ========================================
// Cabinet I/O testbench
// Random loader writes and sticks, checked
// each cycle against a reference model
// ========================================

`timescale 1ns/1ps
`include "cabinet_io_defines.svh"

module tb_cabinet_io;
	import cabinet_io_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int GAME_WRITES  = 40;
	localparam int DIP_WRITES   = 96;
	localparam int LUNAR_WRITES = 40;
	localparam int MIXED_CYCLES = 300;
	// Every phase below counted in clock cycles
	localparam int TOTAL_CYCLES = RESET_CYCLES + 8 + GAME_WRITES * 4 + 4 + DIP_WRITES * 4
		+ 4 + LUNAR_WRITES * 2 + MIXED_CYCLES + 4;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * CLK_PERIOD;

	logic            clk_12;
	logic            reset;
	download_write_t download;
	joy_word_u       joy_0;
	joy_word_u       joy_1;
	cabinet_ports_t  ports;

	// ========================================
	// Reference model state
	// ========================================
	logic [`CIO_DATA_W-1:0] code_m;
	game_e                  game_m;
	logic [`CIO_DATA_W-1:0] bank_m [0:`CIO_DIP_COUNT-1];
	// Bank write waiting one cycle
	logic                   pend_en;
	logic [2:0]             pend_sel;
	logic [`CIO_DATA_W-1:0] pend_data;
	cabinet_ports_t         ports_m;

	cabinet_io_top uut (
		.clk_12   (clk_12),
		.reset    (reset),
		.download (download),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.ports    (ports)
	);

	initial begin
		clk_12 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_12 = ~clk_12;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired and the run did not finish in time");
		$display("RESULT: FAIL");
		$fatal(1, "Timeout");
	end

	// Codes 0 to 3 follow the enum order and the rest mean no game
	function automatic game_e game_from_code(input logic [`CIO_DATA_W-1:0] code);
		if (code < 8'd4)
			return game_e'({1'b0, code[1:0]});
		return game_none;
	endfunction

	// Expected port layout for each game from the cabinet wiring
	function automatic cabinet_ports_t expected_ports(input game_e g,
		input logic [7:0] sw0, input logic [7:0] sw1, input logic [7:0] sw2,
		input logic [15:0] j0, input logic [15:0] j1);
		cabinet_ports_t p;
		logic up, down, left, right;
		logic f_up, f_down, f_left, f_right;
		logic st1, st2, coin;
		logic [7:0] in0_board;
		up      = j0[3];
		down    = j0[2];
		left    = j0[1];
		right   = j0[0];
		// Player 2 stick bits 3..0 are fire up, down, left, right
		f_right = j0[4] | j1[0];
		f_left  = j0[5] | j1[1];
		f_up    = j0[6] | j1[3];
		f_down  = j0[7] | j1[2];
		st1     = j0[8] | j1[8];
		st2     = j0[9] | j1[9];
		coin    = j0[10] | j1[10];
		in0_board = {2'b10, ~sw2[0], ~sw2[1], 2'b11, ~coin, 1'b1};
		p.in0 = `CIO_PORT_IDLE;
		p.in1 = sw0;
		p.in2 = sw1;
		p.in3 = `CIO_PORT_IDLE;
		p.in4 = `CIO_PORT_IDLE;
		if (g == game_bwidow) begin
			p.in0 = in0_board;
			p.in3 = {4'hf, ~up, ~down, ~left, ~right};
			p.in4 = {1'b1, ~st2, ~st1, 1'b1, ~f_up, ~f_down, ~f_left, ~f_right};
		end else if (g == game_gravitar) begin
			p.in0 = in0_board;
			p.in3 = {3'b111, ~f_left, ~left, ~right, ~f_right, ~f_down};
			p.in4 = {1'b1, ~st2, ~st1, 5'h1f};
		end else if (g == game_lunarbat) begin
			p.in0 = in0_board;
			p.in1 = `CIO_PORT_IDLE;
			p.in2 = `CIO_PORT_IDLE;
			// Active high on this board
			p.in3 = {1'b0, st2, st1, f_left, f_down, f_right, right, left};
		end
		return p;
	endfunction

	// ========================================
	// Model update and checks
	// ========================================
	// Old state feeds each stage before it is overwritten
	task automatic update_model();
		if (reset) begin
			code_m  = '0;
			game_m  = game_bwidow;
			pend_en = 1'b0;
			ports_m = {5{`CIO_PORT_IDLE}};
			for (int i = 0; i < `CIO_DIP_COUNT; i++)
				bank_m[i] = '0;
		end else begin
			ports_m   = expected_ports(game_m, bank_m[0], bank_m[1], bank_m[2], joy_0, joy_1);
			game_m    = game_from_code(code_m);
			if (download.wr && download.index == `CIO_INDEX_GAME)
				code_m = download.data;
			if (pend_en)
				bank_m[pend_sel] = pend_data;
			pend_en   = download.wr && download.index == `CIO_INDEX_DIP
				&& download.addr < `CIO_DIP_COUNT;
			pend_sel  = download.addr[2:0];
			pend_data = download.data;
		end
	endtask

	task automatic check_ports();
		assert (ports === ports_m) else begin
			$display("ERR %0t: ports expected %h, got %h", $time, ports_m, ports);
			$display("RESULT: FAIL");
			$fatal(1, "Port mismatch");
		end
	endtask

	// Outputs are checked 1 ns after the edge and new inputs go in at 2 ns
	task automatic step();
		@(posedge clk_12);
		#1;
		update_model();
		check_ports();
		#1;
	endtask

	// ========================================
	// Stimulus helpers
	// ========================================
	task automatic set_idle_download();
		download = '0;
	endtask

	task automatic set_loader_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		download.wr    = 1'b1;
		download.index = index;
		download.addr  = addr;
		download.data  = data;
	endtask

	task automatic set_game_write(input logic [7:0] code);
		logic [24:0] addr;
		addr = $urandom;
		set_loader_write(`CIO_INDEX_GAME, addr, code);
	endtask

	// Mostly bank hits with some out of range addresses and foreign indexes
	task automatic set_random_dip_write();
		logic [24:0] addr;
		logic [7:0]  data;
		logic [7:0]  index;
		int unsigned kind;
		kind  = $urandom_range(0, 3);
		data  = $urandom;
		addr  = $urandom;
		index = `CIO_INDEX_DIP;
		if (kind <= 1)
			addr = $urandom_range(0, `CIO_DIP_COUNT - 1);
		else if (kind == 2 && addr < `CIO_DIP_COUNT)
			addr = addr + `CIO_DIP_COUNT;
		else if (kind == 3)
			index = $urandom_range(2, 253);
		set_loader_write(index, addr, data);
	endtask

	task automatic set_random_joys();
		logic [15:0] word;
		word  = $urandom;
		joy_0 = word;
		word  = $urandom;
		joy_1 = word;
	endtask

	task automatic set_random_traffic();
		int unsigned pick;
		pick = $urandom_range(0, 7);
		if (pick == 0)
			set_game_write($urandom_range(0, 7));
		else if (pick <= 2)
			set_random_dip_write();
		else
			set_idle_download();
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		void'($urandom(5811));
		reset = 1'b1;
		set_idle_download();
		joy_0 = '0;
		joy_1 = '0;
		repeat (RESET_CYCLES) step();
		reset = 1'b0;

		// Idle ports first and then Black Widow with open switches
		repeat (8) step();

		// Random game codes where 4 to 7 give the defaults
		for (int i = 0; i < GAME_WRITES; i++) begin
			set_game_write($urandom_range(0, 7));
			set_random_joys();
			step();
			set_idle_download();
			repeat (3) begin
				set_random_joys();
				step();
			end
		end

		// Switch bytes under Black Widow where all three are visible
		set_game_write(8'd0);
		step();
		set_idle_download();
		repeat (3) step();
		for (int i = 0; i < DIP_WRITES; i++) begin
			set_random_dip_write();
			set_random_joys();
			step();
			set_idle_download();
			repeat (3) begin
				set_random_joys();
				step();
			end
		end

		// Lunar Battle with switches changing underneath
		set_game_write(8'd2);
		step();
		set_idle_download();
		repeat (3) step();
		for (int i = 0; i < LUNAR_WRITES; i++) begin
			set_loader_write(`CIO_INDEX_DIP, $urandom_range(0, 7), $urandom);
			set_random_joys();
			step();
			set_idle_download();
			set_random_joys();
			step();
		end

		// Everything at once including back to back writes
		repeat (MIXED_CYCLES) begin
			set_random_traffic();
			set_random_joys();
			step();
		end
		set_idle_download();
		repeat (4) step();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== cabinet_io_top.f ====
+incdir+source
source/cabinet_io_pkg.sv
source/download_decoder.sv
source/dip_bank.sv
source/input_mapper.sv
source/cabinet_io_top.sv
bench/tb_cabinet_io.sv

// ==== Bender.yml ====
package:
  name: cabinet_io

sources:
  - include_dirs:
      - source
    files:
      - source/cabinet_io_pkg.sv
      - source/download_decoder.sv
      - source/dip_bank.sv
      - source/input_mapper.sv
      - source/cabinet_io_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_cabinet_io.sv
